//--- Makefile
TOP = tb_wb8

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f wb8.f
	out=$$(./obj_dir/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

//--- bench/tb_wb8.sv
`timescale 1ns/100ps
`default_nettype none

`include "wb8_params.svh"

module tb_wb8;
	import wb8_pkg::*;

	localparam int RAM_BYTES  = `WB8_RAM_BYTES;
	localparam int OP_LIMIT   = 40;
	// directed ops, window fill and the random mix, rounded up
	localparam int N_OPS      = 240;
	localparam int MAX_CYCLES = OP_LIMIT * N_OPS;
	localparam addr_t WIN_BASE = 32'h0000_0100;

	logic   CLK_I;
	logic   RST_I;
	logic   en;
	busop_t op;
	addr_t  addr;
	word_t  wdata;
	word_t  rdata;
	logic   busy;

	byte_t  ref_mem [RAM_BYTES];
	word_t  expect_word;
	logic   chk_rd;
	logic   hit_chk;
	int     errors;
	int     n_tests;
	int     n_pass;
	int     cycle_count;
	integer seed;

	wb8_soc u_dut (
		.CLK_I (CLK_I),
		.RST_I (RST_I),
		.en    (en),
		.op    (op),
		.addr  (addr),
		.wdata (wdata),
		.rdata (rdata),
		.busy  (busy)
	);

	bind bus_wb8 wb8_assert u_assert (
		.CLK_I (CLK_I),
		.RST_I (RST_I),
		.busy  (busy),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.ack   (ack),
		.stall (stall),
		.adr   (adr),
		.scnt  (scnt),
		.acnt  (acnt)
	);

	always #50 CLK_I = ~CLK_I;

	// read result at completion against the memory model
	a_rdata: assert property (@(posedge CLK_I) disable iff (RST_I) chk_rd |-> (rdata == expect_word))
		else begin
			$display("MISMATCH at %0t: rdata %08h, expected %08h", $time,
				$sampled(rdata), $sampled(expect_word));
			errors++;
		end

	// busy only rises after a request
	a_idle: assert property (@(posedge CLK_I) disable iff (RST_I) !en |=> !busy)
		else begin
			$display("busy went high at %0t without a request", $time);
			errors++;
		end

	// a cached word read is busy for one cycle and leaves the bus alone
	a_hit: assert property (@(posedge CLK_I) disable iff (RST_I)
		(hit_chk && $past(en && !busy, 2)) |->
		(!busy && $past(busy) && !u_dut.u_bus.cyc && !$past(u_dut.u_bus.cyc)))
		else begin
			$display("cache hit at %0t did not finish in one quiet cycle", $time);
			errors++;
		end

	always @(posedge CLK_I) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout, run went past %0d cycles", MAX_CYCLES);
			$display("Test failures found");
			$finish;
		end
	end

	function automatic int total_errors();
		return errors + u_dut.u_bus.u_assert.fail_count;
	endfunction

	function automatic int mem_index(input addr_t a, input int i);
		return (int'(a) + i) & (RAM_BYTES - 1);
	endfunction

	function automatic int op_bytes(input busop_t o);
		case (o)
			READW, WRITEW:         return 4;
			READH, READHU, WRITEH: return 2;
			default:               return 1;
		endcase
	endfunction

	function automatic bit is_read(input busop_t o);
		return o inside {READB, READBU, READH, READHU, READW};
	endfunction

	// little endian, sign taken from the top byte read
	function automatic word_t model_read(input busop_t o, input addr_t a);
		byte_t b [4];
		word_t v;
		for (int i = 0; i < 4; i++) begin
			b[i] = ref_mem[mem_index(a, i)];
		end
		case (o)
			READB:   v = {{24{b[0][7]}}, b[0]};
			READBU:  v = {24'h0, b[0]};
			READH:   v = {{16{b[1][7]}}, b[1], b[0]};
			READHU:  v = {16'h0, b[1], b[0]};
			default: v = {b[3], b[2], b[1], b[0]};
		endcase
		return v;
	endfunction

	function automatic void model_write(input busop_t o, input addr_t a, input word_t d);
		for (int i = 0; i < op_bytes(o); i++) begin
			ref_mem[mem_index(a, i)] = d[8*i +: 8];
		end
	endfunction

	// one request, keep holds en high so the next one starts at once
	task automatic do_op(input busop_t o, input addr_t a, input word_t d, input bit keep);
		int cycles;
		op     = o;
		addr   = a;
		wdata  = d;
		en     = 1'b1;
		cycles = 0;
		@(posedge CLK_I);
		#1;
		chk_rd = 1'b0;
		while (busy && cycles < OP_LIMIT) begin
			@(posedge CLK_I);
			#1;
			cycles++;
		end
		if (busy) begin
			$display("%s at %08h did not complete within %0d cycles", o.name(), a, OP_LIMIT);
			errors++;
		end else if (is_read(o)) begin
			expect_word = model_read(o, a);
			chk_rd      = 1'b1;
		end else begin
			model_write(o, a, d);
		end
		if (!keep) begin
			en = 1'b0;
		end
	endtask

	task automatic test_done(input string name, input int err_before);
		// one more edge so checks on the last op are sampled
		@(posedge CLK_I);
		#1;
		chk_rd  = 1'b0;
		hit_chk = 1'b0;
		n_tests++;
		if (total_errors() == err_before) begin
			n_pass++;
			$display("test %s: pass", name);
		end else begin
			$display("test %s: FAIL, %0d errors", name, total_errors() - err_before);
		end
	endtask

	initial begin
		int     e0;
		busop_t ro;
		addr_t  ra;
		word_t  rd;
		CLK_I       = 1'b0;
		RST_I       = 1'b1;
		en          = 1'b0;
		op          = READW;
		addr        = '0;
		wdata       = '0;
		expect_word = '0;
		chk_rd      = 1'b0;
		hit_chk     = 1'b0;
		errors      = 0;
		n_tests     = 0;
		n_pass      = 0;
		cycle_count = 0;
		seed        = 32'h4cc4;
		repeat (4) @(posedge CLK_I);
		#1;
		RST_I = 1'b0;

		e0 = total_errors();
		repeat (5) @(posedge CLK_I);
		#1;
		test_done("reset_state", e0);

		e0 = total_errors();
		do_op(WRITEW, 32'h10, 32'hdead_beef, 1'b0);
		do_op(READW, 32'h10, '0, 1'b0);
		for (int i = 0; i < 4; i++) begin
			do_op(WRITEB, 32'h20 + addr_t'(i), word_t'(8'h11 * (i + 1)), 1'b0);
		end
		do_op(READW, 32'h20, '0, 1'b0);
		test_done("word_readback", e0);

		e0 = total_errors();
		do_op(WRITEW, 32'h40, 32'h7f80_01ff, 1'b0);
		do_op(WRITEW, 32'h44, 32'h8001_7ffe, 1'b0);
		do_op(READB, 32'h40, '0, 1'b0);
		do_op(READBU, 32'h40, '0, 1'b0);
		do_op(READB, 32'h41, '0, 1'b0);
		do_op(READBU, 32'h41, '0, 1'b0);
		do_op(READH, 32'h44, '0, 1'b0);
		do_op(READHU, 32'h44, '0, 1'b0);
		do_op(READH, 32'h46, '0, 1'b0);
		do_op(READHU, 32'h46, '0, 1'b0);
		test_done("extension", e0);

		e0 = total_errors();
		do_op(WRITEW, 32'h80, 32'h1234_5678, 1'b0);
		do_op(READW, 32'h80, '0, 1'b0);
		hit_chk = 1'b1;
		do_op(READW, 32'h80, '0, 1'b0);
		test_done("cache_hit", e0);

		e0 = total_errors();
		do_op(WRITEW, 32'hc0, 32'haabb_ccdd, 1'b0);
		do_op(READW, 32'hc0, '0, 1'b0);
		do_op(WRITEB, 32'hc2, 32'h0000_005a, 1'b0);
		do_op(READW, 32'hc0, '0, 1'b0);
		test_done("write_invalidate", e0);

		e0 = total_errors();
		// known contents for the whole window first
		for (int i = 0; i < 8; i++) begin
			do_op(WRITEW, WIN_BASE + addr_t'(4 * i), $random(seed), 1'b1);
		end
		for (int i = 0; i < 200; i++) begin
			ro = busop_t'($random(seed) & 7);
			ra = addr_t'($random(seed) & 31);
			rd = $random(seed);
			if (op_bytes(ro) == 4) begin
				ra[1:0] = 2'b00;
			end else if (op_bytes(ro) == 2) begin
				ra[0] = 1'b0;
			end
			do_op(ro, WIN_BASE + ra, rd, i < 199);
		end
		test_done("random_mix", e0);

		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			n_tests, n_pass, n_tests - n_pass, total_errors());
		if (total_errors() == 0 && n_pass == n_tests) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/wb8_assert.sv
`timescale 1ns/100ps
`default_nettype none

module wb8_assert (
	input wire                   CLK_I,
	input wire                   RST_I,
	input wire                   busy,
	input wire                   cyc,
	input wire                   stb,
	input wire                   we,
	input wire                   ack,
	input wire                   stall,
	input wire wb8_pkg::addr_t   adr,
	input wire wb8_pkg::bcount_t scnt,
	input wire wb8_pkg::bcount_t acnt
);
	int fail_count = 0;

	// a strobe only exists inside a bus cycle
	a_stb_in_cyc: assert property (@(posedge CLK_I) disable iff (RST_I) stb |-> cyc)
		else begin
			$error("stb high while cyc is low");
			fail_count++;
		end

	// direction is fixed for the whole cycle
	a_we_stable: assert property (@(posedge CLK_I) disable iff (RST_I)
		(cyc && $past(cyc)) |-> $stable(we))
		else begin
			$error("we changed inside a bus cycle");
			fail_count++;
		end

	// every ack belongs to a strobe already taken
	a_ack_bound: assert property (@(posedge CLK_I) disable iff (RST_I)
		(cyc && ack) |-> (acnt < scnt))
		else begin
			$error("ack arrived without an outstanding strobe");
			fail_count++;
		end

	// back-pressure freezes the request
	a_stall_hold: assert property (@(posedge CLK_I) disable iff (RST_I)
		(stb && stall) |=> (stb && $stable(adr)))
		else begin
			$error("stb or adr moved while stalled");
			fail_count++;
		end

	a_reset_idle: assert property (@(posedge CLK_I) RST_I |=> (!busy && !cyc && !stb))
		else begin
			$error("busy, cyc or stb high after reset");
			fail_count++;
		end

endmodule

`default_nettype wire

//--- include/wb8_params.svh
`ifndef WB8_PARAMS_SVH
`define WB8_PARAMS_SVH

// size of the byte RAM, the RAM ignores address bits above it
`define WB8_RAM_BYTES 1024

// cycles from an accepted strobe to its acknowledge
`define WB8_ACK_LATENCY 2

// most requests the RAM holds at once
`define WB8_QUEUE_DEPTH 2

// word cache lines, must be a power of two
`define WB8_CACHE_LINES 8

`endif

//--- src/bus_wb8.sv
`timescale 1ns/100ps
`default_nettype none

module bus_wb8 (
	input  wire                  CLK_I,
	input  wire                  RST_I,
	input  wire                  en,
	input  wire wb8_pkg::busop_t op,
	input  wire wb8_pkg::addr_t  addr,
	input  wire wb8_pkg::word_t  wdata,
	output wb8_pkg::word_t       rdata,
	output logic                 busy,
	output wb8_pkg::addr_t       adr,
	output wb8_pkg::byte_t       dat_m,
	input  wire wb8_pkg::byte_t  dat_s,
	output logic                 cyc,
	output logic                 stb,
	output logic                 we,
	input  wire                  ack,
	input  wire                  stall,
	input  wire                  hit,
	input  wire wb8_pkg::word_t  cache_rdata,
	output logic                 fill,
	output wb8_pkg::addr_t       fill_addr,
	output wb8_pkg::word_t       fill_data,
	output logic                 inval,
	output wb8_pkg::addr_t       inval_addr
);
	import wb8_pkg::*;

	bcount_t nbytes;
	logic    is_write;
	logic    is_signed;
	bcount_t scnt;
	bcount_t acnt;
	bcount_t scnt_inc;
	bcount_t acnt_inc;
	logic    from_cache;
	logic    accept;
	logic    last_ack;
	logic    sign;

	// bytes per operation
	always_comb begin
		case (op)
			READW, WRITEW:         nbytes = 3'd4;
			READH, READHU, WRITEH: nbytes = 3'd2;
			default:               nbytes = 3'd1;
		endcase
	end

	assign is_write  = (op == WRITEB) || (op == WRITEH) || (op == WRITEW);
	assign is_signed = (op == READB) || (op == READH);

	assign accept   = stb && !stall;
	assign scnt_inc = scnt + 3'd1;
	assign acnt_inc = acnt + 3'd1;
	assign last_ack = ack && (acnt_inc == nbytes);
	// only byte 0 and the top byte of a halfword carry the sign
	assign sign     = is_signed && dat_s[7];

	// the last byte is still on dat_s, so the fill word takes it from there
	assign fill       = cyc && !we && (op == READW) && last_ack;
	assign fill_addr  = addr;
	assign fill_data  = {dat_s, rdata[23:0]};
	assign inval      = accept && we;
	assign inval_addr = adr;

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			busy       <= 1'b0;
			cyc        <= 1'b0;
			stb        <= 1'b0;
			we         <= 1'b0;
			from_cache <= 1'b0;
			scnt       <= '0;
			acnt       <= '0;
		end else if (!busy) begin
			if (en) begin
				busy <= 1'b1;
				scnt <= '0;
				acnt <= '0;
				if (op == READW && hit) begin
					// word is cached, no bus cycle at all
					from_cache <= 1'b1;
					rdata      <= cache_rdata;
				end else begin
					cyc   <= 1'b1;
					stb   <= 1'b1;
					we    <= is_write;
					adr   <= addr;
					dat_m <= wdata[7:0];
				end
			end
		end else if (from_cache) begin
			busy       <= 1'b0;
			from_cache <= 1'b0;
		end else begin
			// next strobe only once the current one is taken
			if (accept) begin
				scnt <= scnt_inc;
				if (scnt_inc == nbytes) begin
					stb <= 1'b0;
				end else begin
					adr   <= addr + addr_t'(scnt_inc);
					dat_m <= wdata[{scnt_inc[1:0], 3'b000} +: 8];
				end
			end
			if (ack) begin
				acnt <= acnt_inc;
				if (!we) begin
					case (acnt)
						3'd0:    rdata       <= {{24{sign}}, dat_s};
						3'd1:    rdata[31:8] <= {{16{sign}}, dat_s};
						3'd2:    rdata[23:16] <= dat_s;
						default: rdata[31:24] <= dat_s;
					endcase
				end
				if (acnt_inc == nbytes) begin
					busy <= 1'b0;
					cyc  <= 1'b0;
					we   <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- src/wb8_pkg.sv
`default_nettype none

package wb8_pkg;

	// load/store operations of the processor port
	typedef enum logic [2:0] {
		READB  = 3'd0,
		READBU = 3'd1,
		READH  = 3'd2,
		READHU = 3'd3,
		READW  = 3'd4,
		WRITEB = 3'd5,
		WRITEH = 3'd6,
		WRITEW = 3'd7
	} busop_t;

	// byte address, shared by processor port and bus
	typedef logic [31:0] addr_t;

	// processor side data word
	typedef logic [31:0] word_t;

	// one Wishbone data byte
	typedef logic [7:0] byte_t;

	// counts bytes of one operation, 0 to 4
	typedef logic [2:0] bcount_t;

endpackage

`default_nettype wire

//--- src/wb8_ram.sv
`timescale 1ns/100ps
`default_nettype none

`include "wb8_params.svh"

module wb8_ram (
	input  wire                 CLK_I,
	input  wire                 RST_I,
	input  wire                 cyc,
	input  wire                 stb,
	input  wire                 we,
	input  wire wb8_pkg::addr_t adr,
	input  wire wb8_pkg::byte_t dat_m,
	output wb8_pkg::byte_t      dat_s,
	output logic                ack,
	output logic                stall
);
	import wb8_pkg::*;

	localparam int DEPTH = `WB8_QUEUE_DEPTH;
	localparam int LAT   = `WB8_ACK_LATENCY;
	localparam int AW    = $clog2(`WB8_RAM_BYTES);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int LAT_W = $clog2(LAT + 1);

	byte_t            mem [`WB8_RAM_BYTES];
	byte_t            q_data [DEPTH];
	logic [LAT_W-1:0] q_lat [DEPTH];
	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;
	logic [AW-1:0]    idx;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		next_ptr = (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign idx   = adr[AW-1:0];
	assign stall = (count == CNT_W'(DEPTH));
	assign push  = cyc && stb && !stall;
	// head leaves once its latency has run out
	assign pop   = (count != '0) && (q_lat[head] == '0);
	assign ack   = pop;
	assign dat_s = q_data[head];

	always_ff @(posedge CLK_I) begin
		if (push) begin
			if (we) begin
				mem[idx] <= dat_m;
			end
			q_data[tail] <= mem[idx];
		end
		for (int i = 0; i < DEPTH; i++) begin
			if (push && tail == PTR_W'(i)) begin
				q_lat[i] <= LAT_W'(LAT - 1);
			end else if (q_lat[i] != '0) begin
				q_lat[i] <= q_lat[i] - 1'b1;
			end
		end
	end

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (push) begin
				tail <= next_ptr(tail);
			end
			if (pop) begin
				head <= next_ptr(head);
			end
			count <= count + CNT_W'(push) - CNT_W'(pop);
		end
	end

endmodule

`default_nettype wire

//--- src/wb8_soc.sv
`timescale 1ns/100ps
`default_nettype none

module wb8_soc (
	input  wire                  CLK_I,
	input  wire                  RST_I,
	input  wire                  en,
	input  wire wb8_pkg::busop_t op,
	input  wire wb8_pkg::addr_t  addr,
	input  wire wb8_pkg::word_t  wdata,
	output wb8_pkg::word_t       rdata,
	output logic                 busy
);
	import wb8_pkg::*;

	// Wishbone between adapter and RAM
	addr_t adr;
	byte_t dat_m;
	byte_t dat_s;
	logic  cyc;
	logic  stb;
	logic  we;
	logic  ack;
	logic  stall;

	// cache side
	logic  hit;
	word_t cache_rdata;
	logic  fill;
	addr_t fill_addr;
	word_t fill_data;
	logic  inval;
	addr_t inval_addr;

	bus_wb8 u_bus (
		.CLK_I       (CLK_I),
		.RST_I       (RST_I),
		.en          (en),
		.op          (op),
		.addr        (addr),
		.wdata       (wdata),
		.rdata       (rdata),
		.busy        (busy),
		.adr         (adr),
		.dat_m       (dat_m),
		.dat_s       (dat_s),
		.cyc         (cyc),
		.stb         (stb),
		.we          (we),
		.ack         (ack),
		.stall       (stall),
		.hit         (hit),
		.cache_rdata (cache_rdata),
		.fill        (fill),
		.fill_addr   (fill_addr),
		.fill_data   (fill_data),
		.inval       (inval),
		.inval_addr  (inval_addr)
	);

	word_cache u_cache (
		.CLK_I       (CLK_I),
		.RST_I       (RST_I),
		.addr        (addr),
		.hit         (hit),
		.cache_rdata (cache_rdata),
		.fill        (fill),
		.fill_addr   (fill_addr),
		.fill_data   (fill_data),
		.inval       (inval),
		.inval_addr  (inval_addr)
	);

	wb8_ram u_ram (
		.CLK_I (CLK_I),
		.RST_I (RST_I),
		.cyc   (cyc),
		.stb   (stb),
		.we    (we),
		.adr   (adr),
		.dat_m (dat_m),
		.dat_s (dat_s),
		.ack   (ack),
		.stall (stall)
	);

endmodule

`default_nettype wire

//--- src/word_cache.sv
`timescale 1ns/100ps
`default_nettype none

`include "wb8_params.svh"

module word_cache (
	input  wire                 CLK_I,
	input  wire                 RST_I,
	input  wire wb8_pkg::addr_t addr,
	output logic                hit,
	output wb8_pkg::word_t      cache_rdata,
	input  wire                 fill,
	input  wire wb8_pkg::addr_t fill_addr,
	input  wire wb8_pkg::word_t fill_data,
	input  wire                 inval,
	input  wire wb8_pkg::addr_t inval_addr
);
	import wb8_pkg::*;

	localparam int LINES = `WB8_CACHE_LINES;
	localparam int IDX_W = $clog2(LINES);
	// word address bits above the index
	localparam int TAG_W = 30 - IDX_W;

	typedef logic [IDX_W-1:0] idx_t;
	typedef logic [TAG_W-1:0] tag_t;

	logic [LINES-1:0] valid;
	tag_t             tags [LINES];
	word_t            data [LINES];

	idx_t look_idx;
	tag_t look_tag;
	idx_t fill_idx;
	tag_t fill_tag;
	idx_t inval_idx;

	assign look_idx  = addr[2 +: IDX_W];
	assign look_tag  = addr[31 -: TAG_W];
	assign fill_idx  = fill_addr[2 +: IDX_W];
	assign fill_tag  = fill_addr[31 -: TAG_W];
	// any byte of a word maps to the same line
	assign inval_idx = inval_addr[2 +: IDX_W];

	// lookup is purely combinational
	assign hit         = valid[look_idx] && (tags[look_idx] == look_tag);
	assign cache_rdata = data[look_idx];

	always_ff @(posedge CLK_I) begin
		if (fill) begin
			tags[fill_idx] <= fill_tag;
			data[fill_idx] <= fill_data;
		end
	end

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			valid <= '0;
		end else begin
			if (fill) begin
				valid[fill_idx] <= 1'b1;
			end
			// invalidate comes last so it beats a fill on the same line
			// the whole line goes, whatever word it holds
			if (inval) begin
				valid[inval_idx] <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- wb8.f
+incdir+include
src/wb8_pkg.sv
src/bus_wb8.sv
src/word_cache.sv
src/wb8_ram.sv
src/wb8_soc.sv
bench/wb8_assert.sv
bench/tb_wb8.sv
